/* hw/dc_geom_pkg.sv */
package dc_geom_pkg;

	// cache shape.
	localparam int num_ways = 2;         // two-way set associative.
	localparam int num_sets = 256;       // sets per way.
	localparam int line_words = 8;       // words per line.

	// cpu byte address, split as tag | index | offset | byte.
	typedef logic [31:0] addr_t;

	// address bits 31..13.
	typedef logic [18:0] tag_t;

	// address bits 12..5, one of num_sets.
	typedef logic [$clog2(num_sets)-1:0] index_t;

	// address bits 4..2, word within the line.
	typedef logic [$clog2(line_words)-1:0] offset_t;

	// way select.
	typedef logic [$clog2(num_ways)-1:0] way_t;

	// one data word.
	typedef logic [31:0] word_t;

	// whole line, word 0 in the low bits.
	typedef word_t [line_words-1:0] line_t;

endpackage

/* hw/dc_dram_pkg.sv */
package dc_dram_pkg;

	// dram is word addressed; byte address >> 2.
	// a line therefore starts on a multiple of 8.
	typedef logic [31:0] dram_addr_t;

	// words moved per burst, one cache line.
	localparam int burst_len = 8;

	// counts accepted words of a burst.
	// one spare bit so the full count fits.
	typedef logic [3:0] burst_cnt_t;

endpackage

/* hw/dc_ifs.sv */
`timescale 1ns/10ps

// lookup result, array to miss controller.
interface lookup_if import dc_geom_pkg::*; ();
	way_t  victim_way;   // way to replace on a miss.
	logic  victim_dirty; // victim holds modified data.
	tag_t  victim_tag;   // tag stored in the victim way.
	logic  miss;         // request with no hit.
	addr_t miss_addr;    // address of the current request.

	modport array (output victim_way, victim_dirty, victim_tag, miss, miss_addr);
	modport ctrl (input victim_way, victim_dirty, victim_tag, miss, miss_addr);
endinterface

// refilled line, refill engine to array.
interface fill_if import dc_geom_pkg::*; ();
	logic   fill_valid;  // one-cycle install strobe.
	way_t   fill_way;
	index_t fill_index;
	tag_t   fill_tag;
	line_t  fill_line;

	modport refill (output fill_valid, fill_way, fill_index, fill_tag, fill_line);
	modport array (input fill_valid, fill_way, fill_index, fill_tag, fill_line);
endinterface

// victim writeback, shared by controller, array and writeback engine.
interface wb_if import dc_geom_pkg::*; ();
	logic   wb_start;    // one-cycle kick from the controller.
	way_t   wb_way;
	index_t wb_index;
	tag_t   wb_tag;
	line_t  wb_line;     // stored victim line, read combinationally.
	logic   wb_done;     // pulse after the last word.

	modport ctrl (output wb_start, wb_way, wb_index, wb_tag, input wb_done);
	modport array (input wb_way, wb_index, output wb_line);
	modport writeback (input wb_start, wb_index, wb_tag, wb_line, output wb_done);
endinterface

/* hw/dc_array.sv */
`timescale 1ns/10ps

module dc_array import dc_geom_pkg::*; (
	input  logic  clock,
	input  logic  rst,
	input  addr_t cpu_addr,
	input  logic  data_req,
	input  logic  wren,
	input  word_t cpu_wr_data,
	input  logic  busy,            // miss in progress, cpu stalled.
	output word_t cpu_rd_data,
	output logic  hit,
	lookup_if.array lookup,
	fill_if.array   fill,
	wb_if.array     wb
);

	tag_t  tag_mem  [num_ways][num_sets]; // tag per way and set.
	line_t data_mem [num_ways][num_sets]; // line data, not reset.

	logic [num_sets-1:0] valid_bits [num_ways];
	logic [num_sets-1:0] dirty_bits [num_ways];
	logic [num_sets-1:0] use_bits   [num_ways]; // set on access, cleared on the other way.

	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;
	logic [num_ways-1:0] way_hit;
	way_t    hit_way;
	way_t    victim;
	logic    complete;

	assign req_tag    = cpu_addr[31:13];
	assign req_index  = cpu_addr[12:5];
	assign req_offset = cpu_addr[4:2];

	// tag compare on both ways.
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			way_hit[w] = valid_bits[w][req_index] && (tag_mem[w][req_index] == req_tag);
		end
	end

	assign hit      = |way_hit;
	assign hit_way  = way_hit[1];                  // way 1 or else way 0.
	assign complete = data_req && hit && !busy;    // request finishes this edge.

	// replacement choice: empty way first, then the least recently used.
	always_comb begin
		if (!valid_bits[0][req_index])
			victim = 1'b0;
		else if (!valid_bits[1][req_index])
			victim = 1'b1;
		else
			victim = use_bits[0][req_index] ? 1'b1 : 1'b0;
	end

	assign lookup.victim_way   = victim;
	assign lookup.victim_dirty = valid_bits[victim][req_index] && dirty_bits[victim][req_index];
	assign lookup.victim_tag   = tag_mem[victim][req_index];
	assign lookup.miss         = data_req && !hit;
	assign lookup.miss_addr    = cpu_addr;

	assign wb.wb_line = data_mem[wb.wb_way][wb.wb_index]; // victim line for the writeback.

	// state bits and read data register.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int w = 0; w < num_ways; w++) begin
				valid_bits[w] <= '0;
				dirty_bits[w] <= '0;
				use_bits[w]   <= '0;
			end
			cpu_rd_data <= '0;
		end else if (fill.fill_valid) begin
			valid_bits[fill.fill_way][fill.fill_index] <= 1'b1;
			dirty_bits[fill.fill_way][fill.fill_index] <= 1'b0;     // fresh from dram.
			use_bits[fill.fill_way][fill.fill_index]   <= 1'b1;
			use_bits[way_t'(~fill.fill_way)][fill.fill_index] <= 1'b0;
		end else if (complete) begin
			use_bits[hit_way][req_index] <= 1'b1;
			use_bits[way_t'(~hit_way)][req_index] <= 1'b0;
			if (wren)
				dirty_bits[hit_way][req_index] <= 1'b1;              // line now differs from dram.
			else
				cpu_rd_data <= data_mem[hit_way][req_index][req_offset];
		end
	end

	// tag and data storage.
	always_ff @(posedge clock) begin
		if (fill.fill_valid) begin
			tag_mem[fill.fill_way][fill.fill_index]  <= fill.fill_tag;
			data_mem[fill.fill_way][fill.fill_index] <= fill.fill_line;
		end else if (complete && wren) begin
			data_mem[hit_way][req_index][req_offset] <= cpu_wr_data; // single word write.
		end
	end

endmodule

/* hw/dc_miss_ctrl.sv */
`timescale 1ns/10ps

module dc_miss_ctrl import dc_geom_pkg::*; (
	input  logic  clock,
	input  logic  rst,
	lookup_if.ctrl lookup,
	wb_if.ctrl     wb,
	output logic  refill_start,
	output addr_t refill_addr,
	output way_t  refill_way,
	input  logic  refill_done,
	output logic  ram_abort
);

	typedef enum logic [1:0] {
		st_idle,       // serving hits.
		st_wb,         // dirty victim going out.
		st_refill      // missing line coming in.
	} state_t;

	state_t state;
	addr_t  miss_addr;  // held request address.
	way_t   miss_way;   // way chosen for replacement.
	tag_t   miss_tag;   // tag of the line being replaced.
	logic   take_miss;

	assign take_miss = (state == st_idle) && lookup.miss;

	// miss sequencing; start strobes last one cycle.
	always_ff @(posedge clock) begin
		if (rst) begin
			state        <= st_idle;
			refill_start <= 1'b0;
			wb.wb_start  <= 1'b0;
		end else begin
			refill_start <= 1'b0;
			wb.wb_start  <= 1'b0;
			case (state)
				st_idle: begin
					if (lookup.miss && lookup.victim_dirty) begin
						state       <= st_wb;       // save victim first.
						wb.wb_start <= 1'b1;
					end else if (lookup.miss) begin
						state        <= st_refill;
						refill_start <= 1'b1;
					end
				end
				st_wb: begin
					if (wb.wb_done) begin
						state        <= st_refill;  // victim is safe in dram.
						refill_start <= 1'b1;
					end
				end
				st_refill: if (refill_done) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// miss address and victim latch.
	always_ff @(posedge clock) begin
		if (take_miss) begin
			miss_addr <= lookup.miss_addr;
			miss_way  <= lookup.victim_way;
			miss_tag  <= lookup.victim_tag;
		end
	end

	assign refill_addr = miss_addr;
	assign refill_way  = miss_way;
	assign wb.wb_way   = miss_way;
	assign wb.wb_index = miss_addr[12:5];
	assign wb.wb_tag   = miss_tag;
	assign ram_abort   = (state != st_idle); // cpu stall.

endmodule

/* hw/dc_refill.sv */
`timescale 1ns/10ps

module dc_refill import dc_geom_pkg::*; import dc_dram_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  logic       refill_start,
	input  addr_t      refill_addr,
	input  way_t       refill_way,
	output logic       refill_done,
	output logic       dram_rd_req,
	output dram_addr_t dram_rd_addr,
	input  word_t      dram_rd_data,
	input  logic       dram_rd_val,
	fill_if.refill     fill
);

	burst_cnt_t word_cnt;  // words received so far.
	addr_t      line_addr; // latched miss address.
	way_t       line_way;
	line_t      line_buf;  // assembled line.

	always_ff @(posedge clock) begin
		if (rst) begin
			dram_rd_req <= 1'b0;
			word_cnt    <= '0;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			if (refill_start) begin
				dram_rd_req <= 1'b1;
				word_cnt    <= '0;
			end else if (dram_rd_req && dram_rd_val) begin
				word_cnt <= word_cnt + 1'b1;
				if (word_cnt == burst_cnt_t'(burst_len - 1)) begin
					dram_rd_req <= 1'b0;  // last word in.
					refill_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (refill_start) begin
			line_addr <= refill_addr;
			line_way  <= refill_way;
		end
		if (dram_rd_req && dram_rd_val)
			line_buf[word_cnt[2:0]] <= dram_rd_data; // words arrive in address order.
	end

	assign dram_rd_addr    = {2'b00, line_addr[31:5], 3'b000}; // line start, word address.
	assign fill.fill_valid = refill_done;   // install with the done pulse.
	assign fill.fill_way   = line_way;
	assign fill.fill_index = line_addr[12:5];
	assign fill.fill_tag   = line_addr[31:13];
	assign fill.fill_line  = line_buf;

endmodule

/* hw/dc_writeback.sv */
`timescale 1ns/10ps

module dc_writeback import dc_geom_pkg::*; import dc_dram_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	wb_if.writeback    wb,
	output logic       dram_wr_req,
	output dram_addr_t dram_wr_addr,
	output word_t      dram_wr_data,
	input  logic       dram_wr_val
);

	burst_cnt_t word_cnt;  // words accepted so far.
	dram_addr_t blk_addr;  // victim block start.

	always_ff @(posedge clock) begin
		if (rst) begin
			dram_wr_req <= 1'b0;
			word_cnt    <= '0;
			wb.wb_done  <= 1'b0;
		end else begin
			wb.wb_done <= 1'b0;
			if (wb.wb_start) begin
				dram_wr_req <= 1'b1;
				word_cnt    <= '0;
			end else if (dram_wr_req && dram_wr_val) begin
				word_cnt <= word_cnt + 1'b1;  // show the next word.
				if (word_cnt == burst_cnt_t'(burst_len - 1)) begin
					dram_wr_req <= 1'b0;
					wb.wb_done  <= 1'b1;      // whole line written.
				end
			end
		end
	end

	// block address from the stored tag and the set.
	always_ff @(posedge clock) begin
		if (wb.wb_start)
			blk_addr <= {2'b00, wb.wb_tag, wb.wb_index, 3'b000};
	end

	assign dram_wr_addr = blk_addr;
	assign dram_wr_data = wb.wb_line[word_cnt[2:0]]; // current word of the victim.

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top import dc_geom_pkg::*; import dc_dram_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  addr_t      cpu_addr,       // byte address.
	input  logic       data_req,
	input  logic       wren,           // 1 write, 0 read.
	input  word_t      cpu_wr_data,
	output word_t      cpu_rd_data,    // valid one cycle after a read hit.
	output logic       hit,
	output logic       ram_abort,      // cpu stall.
	output logic       dram_rd_req,
	output dram_addr_t dram_rd_addr,
	input  word_t      dram_rd_data,
	input  logic       dram_rd_val,
	output logic       dram_wr_req,
	output dram_addr_t dram_wr_addr,
	output word_t      dram_wr_data,
	input  logic       dram_wr_val
);

	logic  refill_start;
	addr_t refill_addr;
	way_t  refill_way;
	logic  refill_done;

	lookup_if lookup ();
	fill_if   fill ();
	wb_if     wb ();

	dc_array i_array (
		.clock, .rst, .cpu_addr, .data_req, .wren, .cpu_wr_data,
		.busy(ram_abort), .cpu_rd_data, .hit,
		.lookup(lookup.array), .fill(fill.array), .wb(wb.array)
	);

	dc_miss_ctrl i_miss_ctrl (
		.clock, .rst, .lookup(lookup.ctrl), .wb(wb.ctrl),
		.refill_start, .refill_addr, .refill_way, .refill_done, .ram_abort
	);

	dc_refill i_refill (
		.clock, .rst, .refill_start, .refill_addr, .refill_way, .refill_done,
		.dram_rd_req, .dram_rd_addr, .dram_rd_data, .dram_rd_val,
		.fill(fill.refill)
	);

	dc_writeback i_writeback (
		.clock, .rst, .wb(wb.writeback),
		.dram_wr_req, .dram_wr_addr, .dram_wr_data, .dram_wr_val
	);

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;  // 10 ns period.
	end

	// reset held for the first five rising edges.
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
	end

endmodule

/* dv/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb import dc_geom_pkg::*; import dc_dram_pkg::*; ();

	logic       clock, rst;
	addr_t      cpu_addr;
	logic       data_req, wren, hit, ram_abort;
	word_t      cpu_wr_data, cpu_rd_data;
	logic       dram_rd_req, dram_wr_req;
	dram_addr_t dram_rd_addr, dram_wr_addr;
	word_t      dram_rd_data = '0;
	logic       dram_rd_val = 1'b0;
	word_t      dram_wr_data;
	logic       dram_wr_val = 1'b0;

	word_t      dram_mem [dram_addr_t]; // words written back by the cache.
	word_t      shadow [dram_addr_t];   // every completed cpu write.
	dram_addr_t rd_addrs [$];           // start address of each read burst.
	dram_addr_t wr_addrs [$];           // start address of each write burst.
	logic [31:0] stim_lfsr = 32'hdb41_07ad;
	logic [31:0] rd_lfsr = 32'hdb41_07ad;
	logic [31:0] wr_lfsr = 32'hdb41_07ad;
	int rd_cnt, rd_gap, wr_iss, wr_acc, wr_gap;
	int word_errs, hit_errs, addr_errs, burst_errs, timeouts, reads;
	word_t rd_exp;

	// tag side model covering both ways of every set.
	logic m_valid [num_ways][num_sets];
	logic m_dirty [num_ways][num_sets];
	tag_t m_tag   [num_ways][num_sets];
	way_t m_mru   [num_sets];

	tb_clock i_clock (.clock, .rst);

	dcache_top i_dut (.*);

	// 32-bit fibonacci lfsr with taps 32 22 2 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(inout logic [31:0] s, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			s = lfsr_step(s);
			v = {v[30:0], s[0]};  // one step per bit.
		end
	endtask

	// power-up dram content mixes the whole word address.
	function automatic word_t dram_init(input dram_addr_t wa);
		return (wa * 32'h9e37_79b9) ^ {wa[15:0], wa[31:16]};
	endfunction

	function automatic word_t dram_word(input dram_addr_t wa);
		if (dram_mem.exists(wa))
			return dram_mem[wa];
		return dram_init(wa);
	endfunction

	// expected word is the last cpu write, else the dram content.
	function automatic word_t ref_word(input addr_t a);
		if (shadow.exists({2'b00, a[31:2]}))
			return shadow[{2'b00, a[31:2]}];
		return dram_init({2'b00, a[31:2]});
	endfunction

	function automatic addr_t make_addr(input tag_t t, input index_t s, input offset_t o);
		return {t, s, o, 2'b00};
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			word_errs++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_hit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			hit_errs++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_dram_addr(input dram_addr_t got, input dram_addr_t exp,
		input string what);
		if (got !== exp) begin
			addr_errs++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		int total;
		total = word_errs + hit_errs + addr_errs + burst_errs + timeouts;
		$display("errors: data %0d, hit %0d, dram address %0d, burst count %0d, timeout %0d",
			word_errs, hit_errs, addr_errs, burst_errs, timeouts);
		if (total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	// predicts hit and writeback for one access, then updates the model.
	task automatic model_access(input addr_t a, input logic we, output logic is_hit,
		output logic need_wb, output dram_addr_t wb_addr);
		index_t s;
		tag_t   t;
		way_t   w;
		s = a[12:5];
		t = a[31:13];
		is_hit = 1'b0;
		need_wb = 1'b0;
		wb_addr = '0;
		w = 1'b0;
		for (int i = 0; i < num_ways; i++) begin
			if (m_valid[i][s] && m_tag[i][s] == t) begin
				is_hit = 1'b1;
				w = way_t'(i);
			end
		end
		if (!is_hit) begin
			if (!m_valid[0][s])
				w = 1'b0;              // empty way 0 first.
			else if (!m_valid[1][s])
				w = 1'b1;
			else
				w = ~m_mru[s];         // least recently used.
			need_wb = m_valid[w][s] && m_dirty[w][s];
			wb_addr = dram_addr_t'(make_addr(m_tag[w][s], s, '0) / 4);
			m_valid[w][s] = 1'b1;
			m_tag[w][s] = t;
			m_dirty[w][s] = 1'b0;
		end
		if (we)
			m_dirty[w][s] = 1'b1;
		m_mru[s] = w;
	endtask

	// drives one cpu request and holds it until it completes.
	task automatic access(input addr_t a, input logic we, input word_t d);
		logic exp_hit, exp_wb;
		dram_addr_t exp_wb_addr;
		int t;
		model_access(a, we, exp_hit, exp_wb, exp_wb_addr);
		@(posedge clock);
		cpu_addr <= a;
		wren <= we;
		cpu_wr_data <= d;
		data_req <= 1'b1;
		@(negedge clock);
		check_hit(hit, exp_hit, "hit flag");
		if (exp_hit)
			check_hit(ram_abort, 1'b0, "ram_abort on a hit");
		t = 0;
		while (!(hit && !ram_abort) && t < 200) begin
			@(negedge clock);
			t++;
		end
		if (t >= 200) begin
			$display("request to %h never completed, the cache stayed stalled", a);
			timeouts++;
			finish_run();
		end
		@(posedge clock);             // completing edge.
		data_req <= 1'b0;
		if (we)
			shadow[{2'b00, a[31:2]}] = d;
		if (rd_addrs.size() != (exp_hit ? 0 : 1)) begin
			burst_errs++;
			$display("%0d read bursts seen for access to %h", rd_addrs.size(), a);
		end else if (!exp_hit) begin
			check_dram_addr(rd_addrs[0], dram_addr_t'(a / 4) & ~dram_addr_t'(line_words - 1),
				"refill address");
		end
		if (wr_addrs.size() != (exp_wb ? 1 : 0)) begin
			burst_errs++;
			$display("%0d write bursts seen for access to %h", wr_addrs.size(), a);
		end else if (exp_wb) begin
			check_dram_addr(wr_addrs[0], exp_wb_addr, "writeback address");
		end
		rd_addrs.delete();
		wr_addrs.delete();
	endtask

	// dram read side waits a random 0 to 3 cycles before each word.
	always @(posedge clock) begin
		logic [31:0] g;
		if (rst) begin
			dram_rd_val <= 1'b0;
			rd_cnt = 0;
			rd_gap = 0;
		end else begin
			dram_rd_val <= 1'b0;
			if (!dram_rd_req) begin
				rd_cnt = 0;
			end else if (rd_cnt < burst_len) begin
				if (rd_gap > 0) begin
					rd_gap--;
				end else begin
					if (rd_cnt == 0)
						rd_addrs.push_back(dram_rd_addr);
					dram_rd_val <= 1'b1;
					dram_rd_data <= dram_word(dram_rd_addr + dram_addr_t'(rd_cnt));
					rd_cnt++;
					draw(rd_lfsr, 2, g);
					rd_gap = int'(g);
				end
			end
		end
	end

	// each dram write val pulse takes the word shown.
	always @(posedge clock) begin
		logic [31:0] g;
		dram_addr_t  wa;
		if (rst) begin
			dram_wr_val <= 1'b0;
			wr_iss = 0;
			wr_acc = 0;
			wr_gap = 0;
		end else begin
			dram_wr_val <= 1'b0;
			if (dram_wr_req && dram_wr_val) begin
				wa = dram_wr_addr + dram_addr_t'(wr_acc);
				check_word(dram_wr_data, ref_word({wa[29:0], 2'b00}), "writeback word");
				dram_mem[wa] = dram_wr_data;
				wr_acc++;
			end
			if (!dram_wr_req) begin
				wr_iss = 0;
				wr_acc = 0;
			end else if (wr_iss < burst_len) begin
				if (wr_gap > 0) begin
					wr_gap--;
				end else begin
					if (wr_iss == 0)
						wr_addrs.push_back(dram_wr_addr);
					dram_wr_val <= 1'b1;
					wr_iss++;
					draw(wr_lfsr, 2, g);
					wr_gap = int'(g);
				end
			end
		end
	end

	// compares every completed read one cycle later.
	always @(posedge clock) begin
		if (!rst && data_req && hit && !ram_abort && !wren) begin
			rd_exp = ref_word(cpu_addr);
			@(negedge clock);
			check_word(cpu_rd_data, rd_exp, "read data");
			reads++;
		end
	end

	initial begin
		int t;
		logic [31:0] r_tag, r_set, r_off, r_we, r_data;
		cpu_addr = '0;
		data_req = 1'b0;
		wren = 1'b0;
		cpu_wr_data = '0;
		for (int s = 0; s < num_sets; s++) begin
			m_mru[s] = 1'b0;
			for (int w = 0; w < num_ways; w++) begin
				m_valid[w][s] = 1'b0;
				m_dirty[w][s] = 1'b0;
				m_tag[w][s] = '0;
			end
		end
		t = 0;
		while (rst !== 1'b0 && t < 20) begin
			@(posedge clock);
			t++;
		end
		if (rst !== 1'b0) begin
			$display("reset was never released");
			timeouts++;
			finish_run();
		end
		@(negedge clock);
		check_hit(dram_rd_req, 1'b0, "dram_rd_req after reset");
		check_hit(dram_wr_req, 1'b0, "dram_wr_req after reset");
		check_hit(ram_abort, 1'b0, "ram_abort after reset");
		check_hit(hit, 1'b0, "hit after reset");
		check_word(cpu_rd_data, '0, "cpu_rd_data after reset");

		// cold miss followed by hits on the same line.
		access(32'h0000_1044, 1'b0, '0);
		access(32'h0000_1048, 1'b1, 32'hcafe_0001);
		access(32'h0000_1048, 1'b0, '0);
		access(32'h0000_105c, 1'b1, 32'h1234_5678);
		access(32'h0000_105c, 1'b0, '0);
		access(32'h0000_1040, 1'b0, '0);

		// set 5 sees a, b, a again, then c pushes out b.
		access(make_addr(19'd1, 8'd5, 3'd0), 1'b0, '0);
		access(make_addr(19'd2, 8'd5, 3'd1), 1'b0, '0);
		access(make_addr(19'd1, 8'd5, 3'd2), 1'b0, '0);
		access(make_addr(19'd3, 8'd5, 3'd3), 1'b0, '0);
		access(make_addr(19'd1, 8'd5, 3'd4), 1'b0, '0);  // still present.
		access(make_addr(19'd2, 8'd5, 3'd5), 1'b0, '0);  // gone.

		// in set 9 a dirty victim is written back and a clean one dropped.
		access(make_addr(19'd7, 8'd9, 3'd0), 1'b1, 32'h0bad_f00d);
		access(make_addr(19'd7, 8'd9, 3'd7), 1'b1, 32'h7777_0007);
		access(make_addr(19'd8, 8'd9, 3'd2), 1'b0, '0);
		access(make_addr(19'd9, 8'd9, 3'd3), 1'b0, '0);
		access(make_addr(19'd7, 8'd9, 3'd7), 1'b0, '0);
		access(make_addr(19'd8, 8'd9, 3'd0), 1'b0, '0);

		// random mix over four sets and four tags.
		for (int n = 0; n < 400; n++) begin
			draw(stim_lfsr, 2, r_tag);
			draw(stim_lfsr, 2, r_set);
			draw(stim_lfsr, 3, r_off);
			draw(stim_lfsr, 1, r_we);
			draw(stim_lfsr, 32, r_data);
			access(make_addr(tag_t'(r_tag + 32'h40), index_t'(r_set + 32'd16),
				offset_t'(r_off)), r_we[0], r_data);
		end
		repeat (3) @(posedge clock);  // let the last read compare.
		$display("%0d reads compared", reads);
		finish_run();
	end

endmodule

/* sources.f */
hw/dc_geom_pkg.sv
hw/dc_dram_pkg.sv
hw/dc_ifs.sv
hw/dc_array.sv
hw/dc_miss_ctrl.sv
hw/dc_refill.sv
hw/dc_writeback.sv
hw/dcache_top.sv
dv/tb_clock.sv
dv/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache testbench with verilator, run it, look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f sources.f --top-module dcache_tb -o dcache_sim &&
./obj_dir/dcache_sim | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
